// ==== source/mem_uart_pkg.sv ====
package mem_uart_pkg;

	////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////
	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;
	localparam int TAG_W = 32;

	// UART ports in the address map
	localparam logic [ADDR_W-1:0] UART_DATA_ADDR = 16'hBF00;
	localparam logic [ADDR_W-1:0] UART_STAT_ADDR = 16'hBF01;

	// One step every STEP_DIV clocks
	localparam int STEP_DIV = 4;
	localparam int STEP_W = 2;

	localparam int RXQ_DEPTH = 16;
	localparam int RXQ_PTR_W = 4;

	////////////////////////////////////////
	// Controller states
	////////////////////////////////////////
	typedef enum logic [4:0] {
		IDLE,
		RAM_RD1, RAM_RD2, RAM_RD3,
		RAM_WR1, RAM_WR2, RAM_WR3,
		TX1, TX2, TX3, TX4, TX5,
		RX1, RX2, RX3, RX4,
		POP1, POP2,
		STAT
	} ctrl_state_t;

endpackage

// ==== source/rx_byte_queue.sv ====
`timescale 1ns/1ps

module rx_byte_queue (
	input logic clk,
	input logic rst,
	input logic push_en,
	input logic [7:0] push_data,
	input logic pop_en,
	output logic [7:0] front_data,
	output logic not_empty
);
	import mem_uart_pkg::*;

	logic [7:0] mem [RXQ_DEPTH];
	logic [RXQ_PTR_W-1:0] head;
	logic [RXQ_PTR_W-1:0] tail;
	logic [RXQ_PTR_W:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (count == (RXQ_PTR_W+1)'(RXQ_DEPTH));
	assign not_empty = (count != '0);
	// Byte dropped when full
	assign do_push = push_en && !full;
	assign do_pop = pop_en && not_empty;
	assign front_data = mem[head];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[tail] <= push_data;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				tail <= tail + 1'b1;
			end
			if (do_pop) begin
				head <= head + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_push_full: assert property (@(posedge clk) disable iff (!rst) push_en |-> !full);
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst) pop_en |-> not_empty);

endmodule

// ==== source/mem_uart_ctrl.sv ====
`timescale 1ns/1ps

module mem_uart_ctrl (
	input logic clk,
	input logic rst,

	input logic req_valid,
	input logic req_rd,
	input logic req_wr,
	input logic [mem_uart_pkg::ADDR_W-1:0] req_addr,
	input logic [mem_uart_pkg::DATA_W-1:0] req_wdata,
	input logic [mem_uart_pkg::TAG_W-1:0] req_tag,
	output logic done,
	output logic [mem_uart_pkg::DATA_W-1:0] rdata,

	output logic [mem_uart_pkg::ADDR_W-1:0] sram_addr,
	output logic sram_en_n,
	output logic sram_oe_n,
	output logic sram_we_n,
	output logic bus_drive,
	output logic [mem_uart_pkg::DATA_W-1:0] bus_out,
	input logic [mem_uart_pkg::DATA_W-1:0] bus_in,

	output logic uart_rdn,
	output logic uart_wrn,
	input logic uart_data_ready,
	input logic uart_tbre,
	input logic uart_tsre,

	output logic push_en,
	output logic [7:0] push_data,
	output logic pop_en,
	input logic [7:0] front_data,
	input logic not_empty
);
	import mem_uart_pkg::*;

	logic [STEP_W-1:0] step_cnt;
	logic step_tick;
	ctrl_state_t state;
	ctrl_state_t next_state;
	logic new_req;
	logic finish;
	logic [TAG_W-1:0] last_tag;
	logic done_flag;

	// Pin values for a state, as {en_n, oe_n, we_n, rdn, wrn, drive}
	function automatic logic [5:0] state_strobes(ctrl_state_t s);
		logic [5:0] r;
		r = 6'b111110;
		case (s)
			RAM_RD1: r = 6'b011110;
			RAM_RD2, RAM_RD3: r = 6'b001110;
			RAM_WR1: r = 6'b011111;
			RAM_WR2, RAM_WR3: r = 6'b010111;
			TX1, TX2: r = 6'b111101;
			TX3, TX4, TX5: r = 6'b111111;
			RX2, RX3: r = 6'b111010;
			default: r = 6'b111110;
		endcase
		return r;
	endfunction

	assign sram_addr = req_addr;
	assign bus_out = req_wdata;
	assign step_tick = (step_cnt == STEP_W'(STEP_DIV - 1));
	assign new_req = req_valid && (req_tag != last_tag);
	assign finish = state inside {RAM_RD3, RAM_WR3, TX5, POP2, STAT};
	assign done = done_flag && (last_tag == req_tag);

	// Queue side strobes
	assign push_en = step_tick && (state == RX3);
	assign push_data = bus_in[7:0];
	assign pop_en = step_tick && (state == POP2) && not_empty;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			step_cnt <= '0;
		end else if (step_tick) begin
			step_cnt <= '0;
		end else begin
			step_cnt <= step_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////
	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				// Incoming UART byte wins over the CPU
				if (uart_data_ready) begin
					next_state = RX1;
				end else if (new_req) begin
					if (req_addr == UART_DATA_ADDR) begin
						if (req_wr) begin
							next_state = TX1;
						end else if (req_rd) begin
							next_state = POP1;
						end
					end else if (req_addr == UART_STAT_ADDR) begin
						next_state = STAT;
					end else if (req_wr) begin
						next_state = RAM_WR1;
					end else if (req_rd) begin
						next_state = RAM_RD1;
					end
				end
			end
			RAM_RD1: next_state = RAM_RD2;
			RAM_RD2: next_state = RAM_RD3;
			RAM_WR1: next_state = RAM_WR2;
			RAM_WR2: next_state = RAM_WR3;
			TX1: next_state = TX2;
			TX2: next_state = TX3;
			TX3: begin
				if (uart_tbre) begin
					next_state = TX4;
				end
			end
			TX4: begin
				if (uart_tsre) begin
					next_state = TX5;
				end
			end
			RX1: next_state = RX2;
			RX2: next_state = RX3;
			RX3: next_state = RX4;
			POP1: next_state = POP2;
			default: next_state = IDLE;
		endcase
	end

	////////////////////////////////////////
	// State, pins and completion
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= IDLE;
			{sram_en_n, sram_oe_n, sram_we_n, uart_rdn, uart_wrn, bus_drive} <= 6'b111110;
			last_tag <= '1;
			done_flag <= 1'b0;
		end else if (step_tick) begin
			state <= next_state;
			{sram_en_n, sram_oe_n, sram_we_n, uart_rdn, uart_wrn, bus_drive} <=
				state_strobes(next_state);
			if (state == IDLE && next_state != IDLE && next_state != RX1) begin
				done_flag <= 1'b0;
			end
			if (finish) begin
				last_tag <= req_tag;
				done_flag <= 1'b1;
			end
		end
	end

	// Read result
	always_ff @(posedge clk) begin
		if (step_tick) begin
			case (state)
				RAM_RD3: rdata <= bus_in;
				POP1: rdata <= not_empty ? {{(DATA_W-8){1'b0}}, front_data} : '0;
				STAT: begin
					if (req_rd) begin
						rdata <= {{(DATA_W-2){1'b0}}, uart_tbre & uart_tsre, not_empty};
					end
				end
				default: rdata <= rdata;
			endcase
		end
	end

	a_drive_vs_oe: assert property (@(posedge clk) disable iff (!rst)
		!(bus_drive && !sram_oe_n));
	a_uart_strobes: assert property (@(posedge clk) disable iff (!rst)
		!(!uart_rdn && !uart_wrn));

endmodule

// ==== source/mem_uart_top.sv ====
`timescale 1ns/1ps

module mem_uart_top (
	input logic clk,
	input logic rst,

	input logic req_valid,
	input logic req_rd,
	input logic req_wr,
	input logic [mem_uart_pkg::ADDR_W-1:0] req_addr,
	input logic [mem_uart_pkg::DATA_W-1:0] req_wdata,
	input logic [mem_uart_pkg::TAG_W-1:0] req_tag,
	output logic done,
	output logic [mem_uart_pkg::DATA_W-1:0] rdata,

	output logic [mem_uart_pkg::ADDR_W-1:0] sram_addr,
	output logic sram_en_n,
	output logic sram_oe_n,
	output logic sram_we_n,
	output logic bus_drive,
	output logic [mem_uart_pkg::DATA_W-1:0] bus_out,
	input logic [mem_uart_pkg::DATA_W-1:0] bus_in,

	output logic uart_rdn,
	output logic uart_wrn,
	input logic uart_data_ready,
	input logic uart_tbre,
	input logic uart_tsre
);

	logic push_en;
	logic [7:0] push_data;
	logic pop_en;
	logic [7:0] front_data;
	logic not_empty;

	mem_uart_ctrl i_ctrl (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_rd(req_rd), .req_wr(req_wr),
		.req_addr(req_addr), .req_wdata(req_wdata), .req_tag(req_tag),
		.done(done), .rdata(rdata),
		.sram_addr(sram_addr), .sram_en_n(sram_en_n),
		.sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n),
		.bus_drive(bus_drive), .bus_out(bus_out), .bus_in(bus_in),
		.uart_rdn(uart_rdn), .uart_wrn(uart_wrn),
		.uart_data_ready(uart_data_ready), .uart_tbre(uart_tbre), .uart_tsre(uart_tsre),
		.push_en(push_en), .push_data(push_data), .pop_en(pop_en),
		.front_data(front_data), .not_empty(not_empty)
	);

	// Bytes fetched from the UART chip
	rx_byte_queue i_rxq (
		.clk(clk), .rst(rst),
		.push_en(push_en), .push_data(push_data), .pop_en(pop_en),
		.front_data(front_data), .not_empty(not_empty)
	);

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		rst = 1'b0;
		repeat (8) @(posedge clk);
		#2 rst = 1'b1;
	end
endmodule

// ==== dv/board_bus_model.sv ====
`timescale 1ns/1ps

module board_bus_model (
	input logic clk,
	input logic [15:0] sram_addr,
	input logic sram_en_n,
	input logic sram_oe_n,
	input logic sram_we_n,
	input logic bus_drive,
	input logic [15:0] bus_out,
	output logic [15:0] bus_in,
	input logic uart_rdn,
	input logic uart_wrn,
	output logic uart_data_ready = 1'b0,
	output logic uart_tbre,
	output logic uart_tsre
);
	logic [15:0] sram [65536];
	logic [7:0] rx_fifo [$];
	logic [7:0] tx_log [$];
	logic [7:0] rx_front = 8'h00;
	logic prev_rdn = 1'b1;
	logic prev_wrn = 1'b1;
	int tx_cnt = 0;

	initial begin
		for (int i = 0; i < 65536; i++) begin
			sram[i] = {i[7:0], i[15:8]} ^ 16'h3C5A;
		end
	end

	// Shared bus as the board would resolve it
	assign bus_in = bus_drive ? bus_out :
		(!sram_en_n && !sram_oe_n) ? sram[sram_addr] :
		!uart_rdn ? {8'h00, rx_front} : 16'h0000;
	assign uart_tbre = (tx_cnt <= 12);
	assign uart_tsre = (tx_cnt == 0);

	function automatic int rx_pending();
		return rx_fifo.size();
	endfunction
	function automatic int tx_count();
		return tx_log.size();
	endfunction
	function automatic logic [7:0] tx_byte(int i);
		return tx_log[i];
	endfunction
	task automatic inject_byte(logic [7:0] b);
		rx_fifo.push_back(b);
	endtask

	always @(posedge clk) begin
		if (!sram_en_n && !sram_we_n && bus_drive) begin
			sram[sram_addr] <= bus_in;
		end
		prev_rdn <= uart_rdn;
		prev_wrn <= uart_wrn;
		// Byte leaves the chip once the read strobe ends
		if (!prev_rdn && uart_rdn && rx_fifo.size() != 0) begin
			void'(rx_fifo.pop_front());
		end
		uart_data_ready <= (rx_fifo.size() != 0);
		rx_front <= (rx_fifo.size() != 0) ? rx_fifo[0] : 8'h00;
		if (!prev_wrn && uart_wrn) begin
			tx_log.push_back(bus_in[7:0]);
			tx_cnt <= 24;
		end else if (tx_cnt != 0) begin
			tx_cnt <= tx_cnt - 1;
		end
	end
endmodule

// ==== dv/tb_mem_uart.sv ====
`timescale 1ns/1ps

module tb_mem_uart;
	logic clk, rst, req_valid, req_rd, req_wr, done, bus_drive;
	logic sram_en_n, sram_oe_n, sram_we_n, uart_rdn, uart_wrn;
	logic uart_data_ready, uart_tbre, uart_tsre, ok;
	logic [15:0] req_addr, req_wdata, rdata, sram_addr, bus_out, bus_in;
	logic [15:0] f_op, f_addr, f_data, f_exp, word;
	logic [31:0] req_tag, rng;
	logic [15:0] shadow [logic [15:0]];
	int pass_cnt, fail_cnt, fd, n, n0, line_no;
	string line, name;

	tb_clock i_clock (.clk(clk), .rst(rst));

	board_bus_model i_board (.clk(clk), .sram_addr(sram_addr), .sram_en_n(sram_en_n),
		.sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n), .bus_drive(bus_drive),
		.bus_out(bus_out), .bus_in(bus_in), .uart_rdn(uart_rdn), .uart_wrn(uart_wrn),
		.uart_data_ready(uart_data_ready), .uart_tbre(uart_tbre), .uart_tsre(uart_tsre));

	mem_uart_top i_dut (.clk(clk), .rst(rst), .req_valid(req_valid), .req_rd(req_rd),
		.req_wr(req_wr), .req_addr(req_addr), .req_wdata(req_wdata), .req_tag(req_tag),
		.done(done), .rdata(rdata), .sram_addr(sram_addr), .sram_en_n(sram_en_n),
		.sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n), .bus_drive(bus_drive),
		.bus_out(bus_out), .bus_in(bus_in), .uart_rdn(uart_rdn), .uart_wrn(uart_wrn),
		.uart_data_ready(uart_data_ready), .uart_tbre(uart_tbre), .uart_tsre(uart_tsre));

	function automatic logic [31:0] xorshift(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// Power-up content of the board SRAM
	function automatic logic [15:0] fill_word(logic [15:0] a);
		return {a[7:0], a[15:8]} ^ 16'h3C5A;
	endfunction

	task automatic check_value(string t, logic [15:0] exp, logic [15:0] act);
		if (exp !== act) begin
			$display("ERR %s expected %h actual %h", t, exp, act);
			fail_cnt++;
		end else begin
			$display("ok  %s value %h", t, act);
			pass_cnt++;
		end
	endtask

	task automatic report(string t, logic good, string what);
		if (good) begin
			$display("ok  %s", t);
			pass_cnt++;
		end else begin
			$display("%s: %s", t, what);
			fail_cnt++;
		end
	endtask

	// New tag, then wait for done; starts and ends 2 ns after an edge
	task automatic access(logic rd, logic wr, logic [15:0] a, logic [15:0] d);
		int k;
		req_tag = req_tag + 1;
		{req_valid, req_rd, req_wr, req_addr, req_wdata} = {1'b1, rd, wr, a, d};
		ok = 1'b0;
		k = 0;
		while (!ok && k < 400) begin
			@(posedge clk);
			#1;
			k++;
			ok = done;
		end
		#1;
	endtask

	initial begin
		{req_valid, req_rd, req_wr, req_addr, req_wdata} = '0;
		req_tag = '1;
		rng = 32'd11386;
		{pass_cnt, fail_cnt, n, line_no} = '0;
		ok = 1'b1;
		while (n < 30 && (rst !== 1'b1 || n < 12)) begin
			@(posedge clk);
			#1;
			n++;
			if (done !== 1'b0 || bus_drive !== 1'b0 ||
				{sram_en_n, sram_oe_n, sram_we_n, uart_rdn, uart_wrn} !== 5'b11111) begin
				ok = 1'b0;
			end
		end
		#1;
		report("reset_idle", ok && rst === 1'b1, "outputs not idle around reset");
		fd = $fopen("dv/mem_uart_testdata.txt", "r");
		report("open_testdata", fd != 0, "cannot open the test data file");
		while (fd != 0 && !$feof(fd)) begin
			if ($fgets(line, fd) == 0) break;
			line_no++;
			if (line.len() < 7 || line[0] == 8'h23) continue;
			void'($sscanf(line, "%h %h %h %h", f_op, f_addr, f_data, f_exp));
			name = $sformatf("line%0d_op%0d_%h", line_no, f_op, f_addr);
			case (f_op)
				16'd1, 16'd2: begin
					rng = xorshift(rng);
					word = (f_op == 16'd1) ? rng[15:0] : f_data;
					access(1'b0, 1'b1, f_addr, word);
					if (ok) shadow[f_addr] = word;
					report(name, ok, "no done within 400 cycles");
				end
				16'd3: begin
					access(1'b1, 1'b0, f_addr, 16'h0000);
					word = shadow.exists(f_addr) ? shadow[f_addr] : fill_word(f_addr);
					if (!ok) report(name, 1'b0, "no done within 400 cycles");
					else check_value(name, word, rdata);
				end
				16'd4: begin
					// Same tag as the last access, so nothing may happen
					{req_valid, req_rd, req_wr, req_addr, req_wdata} = {3'b101, f_addr, f_data};
					repeat (40) @(posedge clk);
					#2;
					report(name, done === 1'b1, "done dropped for an unchanged tag");
				end
				16'd5: begin
					n0 = i_board.tx_count();
					access(1'b0, 1'b1, f_addr, f_data);
					if (!ok) report(name, 1'b0, "no done within 400 cycles");
					else if (!(uart_tbre && uart_tsre)) report(name, 1'b0, "done before tx idle");
					else if (i_board.tx_count() != n0 + 1) report(name, 1'b0, "wrong tx byte count");
					else check_value(name, f_exp, {8'h00, i_board.tx_byte(n0)});
				end
				16'd6: begin
					i_board.inject_byte(f_data[7:0]);
					n = 0;
					while (i_board.rx_pending() != 0 && n < 400) begin
						@(posedge clk);
						#2;
						n++;
					end
					report(name, i_board.rx_pending() == 0, "injected byte never fetched");
				end
				16'd7, 16'd8: begin
					access(1'b1, 1'b0, f_addr, 16'h0000);
					if (!ok) report(name, 1'b0, "no done within 400 cycles");
					else check_value(name, f_exp, rdata);
				end
				default: report(name, 1'b0, "unknown opcode in test data");
			endcase
		end
		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end
endmodule

// ==== sim.f ====
source/mem_uart_pkg.sv
source/rx_byte_queue.sv
source/mem_uart_ctrl.sv
source/mem_uart_top.sv
dv/tb_clock.sv
dv/board_bus_model.sv
dv/tb_mem_uart.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_mem_uart -o vsim \
	> sim.log 2>&1 || { echo "build failed, see sim.log"; exit 1; }
./obj_dir/vsim >> sim.log 2>&1
grep -qx "TB PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== dv/mem_uart_testdata.txt ====
# op addr data expected, all hex
# op 1 ram write random, 2 ram write data, 3 ram read, 4 rewrite same tag,
# op 5 uart write, 6 inject rx byte, 7 uart read, 8 uart status
1 0010 0000 0000
1 0011 0000 0000
2 1234 BEEF 0000
1 FFFF 0000 0000
3 0010 0000 0000
3 0011 0000 0000
3 1234 0000 0000
3 FFFF 0000 0000
3 0500 0000 0000
2 0011 A5A5 0000
3 0011 0000 0000
4 0011 1111 0000
3 0011 0000 0000
5 BF00 1C55 0055
8 BF01 0000 0002
6 BF00 0041 0000
6 BF00 0042 0000
8 BF01 0000 0003
7 BF00 0000 0041
7 BF00 0000 0042
8 BF01 0000 0002
7 BF00 0000 0000
